/* Bender.yml */
package:
  name: rv_issue

sources:
  - target: any(hw, verif)
    include_dirs:
      - hw
    files:
      - hw/rv_issue_pkg.sv
      - hw/instr_decoder.sv
      - hw/stall_timer.sv
      - hw/reg_file.sv
      - hw/hazard_ctrl.sv
      - hw/rv_issue_top.sv
  - target: verif
    include_dirs:
      - hw
    files:
      - verif/tb_rv_issue.sv

/* filelist.f */
+incdir+hw
hw/rv_issue_pkg.sv
hw/instr_decoder.sv
hw/stall_timer.sv
hw/reg_file.sv
hw/hazard_ctrl.sv
hw/rv_issue_top.sv
verif/tb_rv_issue.sv

/* hw/hazard_ctrl.sv */
`timescale 1ns/1ps
`include "rv_issue_cfg.svh"

module hazard_ctrl
    import rv_issue_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     instr_valid,
    input  dec_t                     dec,
    input  logic [`RV_XLEN-1:0]      rdata_a,
    input  logic [`RV_XLEN-1:0]      rdata_b,
    input  logic                     busy,
    output logic                     load,
    output logic [`RV_STALL_CW-1:0]  load_val,
    output logic                     stall,
    output logic                     issue_valid,
    output issue_t                   issue,
    output logic                     illegal
);

    localparam logic IDLE  = 1'b0;  // No producer tracked
    localparam logic TRACK = 1'b1;  // trk_rd holds a live producer

    localparam logic [`RV_STALL_CW-1:0] ALU_LEN  = `RV_ALU_STALL;
    localparam logic [`RV_STALL_CW-1:0] LOAD_LEN = `RV_LOAD_STALL;

    logic                   state;
    logic [`RV_REG_AW-1:0]  trk_rd;
    logic                   dep;
    logic                   accept;
    logic                   is_illegal;

    // ##############################
    // Dependency check
    // ##############################
    assign is_illegal = (dec.kind == OP_ILLEGAL);
    assign dep = (dec.rs1 == trk_rd) || (dec.uses_rs2 && (dec.rs2 == trk_rd));
    assign stall = instr_valid && (state == TRACK) && !is_illegal && dep && busy;
    assign accept = instr_valid && !stall;

    assign load     = accept && dec.writes_rd;
    assign load_val = (dec.kind == OP_LOAD) ? LOAD_LEN : ALU_LEN;

    // ##############################
    // Producer tracking FSM
    // ##############################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            trk_rd <= '0;
        end else if (accept) begin
            if (dec.writes_rd) begin
                state  <= TRACK;   // Newest producer replaces the old one
                trk_rd <= dec.rd;
            end else begin
                state  <= IDLE;
            end
        end
    end

    // Output strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
            illegal     <= 1'b0;
        end else begin
            issue_valid <= accept && !is_illegal;
            illegal     <= accept && is_illegal;
        end
    end

    // Issue bundle
    always_ff @(posedge clk) begin
        if (accept && !is_illegal) begin
            issue.kind   <= dec.kind;
            issue.rd     <= dec.rd;
            issue.funct3 <= dec.funct3;
            issue.op_a   <= rdata_a;
            issue.op_b   <= (dec.kind == OP_REG) ? rdata_b : dec.imm;
            issue.imm    <= dec.imm;
        end
    end

    a_issue_illegal_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(issue_valid && illegal));

    // A stalled instruction is presented again unchanged
    a_stall_holds_instr: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> (instr_valid && $stable(dec)));

endmodule

/* hw/instr_decoder.sv */
`timescale 1ns/1ps
`include "rv_issue_cfg.svh"

module instr_decoder
    import rv_issue_pkg::*;
(
    input  instr_u instr,
    output dec_t   dec
);

    // Major opcodes handled by this slice
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;

    logic [`RV_XLEN-1:0] imm_i;

    assign imm_i = {{(`RV_XLEN-12){instr.i_view.imm12[11]}}, instr.i_view.imm12};

    always_comb begin
        dec = '0;
        dec.kind = OP_ILLEGAL;  // Default for anything not listed below

        case (instr.r_view.opcode)
            OPC_OP: begin
                dec.kind     = OP_REG;
                dec.rs1      = instr.r_view.rs1;
                dec.rs2      = instr.r_view.rs2;
                dec.uses_rs2 = 1'b1;
                dec.rd       = instr.r_view.rd;
                dec.funct3   = instr.r_view.funct3;
            end
            OPC_OP_IMM: begin
                dec.kind   = OP_IMM;
                dec.rs1    = instr.i_view.rs1;
                dec.rd     = instr.i_view.rd;
                dec.imm    = imm_i;
                dec.funct3 = instr.i_view.funct3;
            end
            OPC_LOAD: begin
                dec.kind   = OP_LOAD;
                dec.rs1    = instr.i_view.rs1;  // Base address
                dec.rd     = instr.i_view.rd;
                dec.imm    = imm_i;             // Offset
                dec.funct3 = instr.i_view.funct3;
            end
            default: begin
                dec.kind = OP_ILLEGAL;
            end
        endcase

        // Writes to x0 are dropped, so they never create a hazard
        dec.writes_rd = (dec.kind != OP_ILLEGAL) && (dec.rd != '0);
    end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps
`include "rv_issue_cfg.svh"

module reg_file
    import rv_issue_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  wb_t                     wb,
    input  logic [`RV_REG_AW-1:0]   raddr_a,
    input  logic [`RV_REG_AW-1:0]   raddr_b,
    output logic [`RV_XLEN-1:0]     rdata_a,
    output logic [`RV_XLEN-1:0]     rdata_b
);

    logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];  // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wb.valid && (wb.addr != '0)) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // Read with x0 forced to zero and same-cycle writeback bypass
    always_comb begin
        if (raddr_a == '0) begin
            rdata_a = '0;
        end else if (wb.valid && (wb.addr == raddr_a)) begin
            rdata_a = wb.data;      // Write-through
        end else begin
            rdata_a = regs[raddr_a];
        end

        if (raddr_b == '0) begin
            rdata_b = '0;
        end else if (wb.valid && (wb.addr == raddr_b)) begin
            rdata_b = wb.data;      // Write-through
        end else begin
            rdata_b = regs[raddr_b];
        end
    end

    // A write to x0 never reaches its read data, not even through the bypass
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (wb.valid && (wb.addr == '0)) |->
            ((raddr_a != '0) || (rdata_a == '0)) && ((raddr_b != '0) || (rdata_b == '0)));

endmodule

/* hw/rv_issue_cfg.svh */
`ifndef RV_ISSUE_CFG_SVH
`define RV_ISSUE_CFG_SVH

// ##############################
// Register file geometry
// ##############################
`define RV_NUM_REGS 32   // Architectural registers x0..x31
`define RV_REG_AW   5    // Register address width
`define RV_XLEN     64   // Data width

// ##############################
// Hazard timing
// ##############################
`define RV_ALU_STALL 1   // Hold cycles behind an ALU producer
`define RV_LOAD_STALL 2  // Hold cycles behind a load producer
`define RV_STALL_CW  2   // Width of the stall counter

`endif

/* hw/rv_issue_pkg.sv */
`include "rv_issue_cfg.svh"

package rv_issue_pkg;

    typedef enum logic [1:0] {
        OP_REG     = 2'd0,  // Register-register
        OP_IMM     = 2'd1,  // Register-immediate
        OP_LOAD    = 2'd2,
        OP_ILLEGAL = 2'd3
    } op_kind_e;

    // One instruction word, read as R-type or I-type by opcode
    typedef union packed {
        struct packed {
            logic [6:0]             funct7;
            logic [`RV_REG_AW-1:0]  rs2;
            logic [`RV_REG_AW-1:0]  rs1;
            logic [2:0]             funct3;
            logic [`RV_REG_AW-1:0]  rd;
            logic [6:0]             opcode;
        } r_view;
        struct packed {
            logic [11:0]            imm12;
            logic [`RV_REG_AW-1:0]  rs1;
            logic [2:0]             funct3;
            logic [`RV_REG_AW-1:0]  rd;
            logic [6:0]             opcode;
        } i_view;
    } instr_u;

    typedef struct packed {
        op_kind_e               kind;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [`RV_REG_AW-1:0]  rs2;
        logic                   uses_rs2;
        logic [`RV_REG_AW-1:0]  rd;
        logic                   writes_rd;  // Legal and rd not x0
        logic [`RV_XLEN-1:0]    imm;        // Sign-extended
        logic [2:0]             funct3;
    } dec_t;

    typedef struct packed {
        logic                   valid;
        logic [`RV_REG_AW-1:0]  addr;
        logic [`RV_XLEN-1:0]    data;
    } wb_t;

    typedef struct packed {
        op_kind_e               kind;
        logic [`RV_REG_AW-1:0]  rd;
        logic [2:0]             funct3;
        logic [`RV_XLEN-1:0]    op_a;
        logic [`RV_XLEN-1:0]    op_b;
        logic [`RV_XLEN-1:0]    imm;
    } issue_t;

endpackage

/* hw/rv_issue_top.sv */
`timescale 1ns/1ps
`include "rv_issue_cfg.svh"

module rv_issue_top
    import rv_issue_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    instr_valid,
    input  instr_u  instr,
    input  wb_t     wb,
    output logic    stall,
    output logic    issue_valid,
    output issue_t  issue,
    output logic    illegal
);

    dec_t                      dec;
    logic [`RV_XLEN-1:0]       rdata_a;
    logic [`RV_XLEN-1:0]       rdata_b;
    logic                      load;
    logic [`RV_STALL_CW-1:0]   load_val;
    logic                      busy;

    instr_decoder u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb      (wb),
        .raddr_a (dec.rs1),
        .raddr_b (dec.rs2),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    stall_timer u_stall_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (load),
        .load_val (load_val),
        .busy     (busy)
    );

    hazard_ctrl u_hazard_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .dec         (dec),
        .rdata_a     (rdata_a),
        .rdata_b     (rdata_b),
        .busy        (busy),
        .load        (load),
        .load_val    (load_val),
        .stall       (stall),
        .issue_valid (issue_valid),
        .issue       (issue),
        .illegal     (illegal)
    );

endmodule

/* hw/stall_timer.sv */
`timescale 1ns/1ps
`include "rv_issue_cfg.svh"

module stall_timer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load,
    input  logic [`RV_STALL_CW-1:0]  load_val,
    output logic                     busy
);

    logic [`RV_STALL_CW-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= load_val;          // New producer restarts the window
        end else if (count != '0) begin
            count <= count - 1'b1;      // Stops at zero
        end
    end

    assign busy = (count != '0);

    // A zero load would drop the hazard window
    a_load_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        load |-> (load_val != '0));

endmodule

/* verif/rv_issue_trace.txt */
// Cols: instr_valid_instr_wbvalid_wbaddr_wbdata_stall_issuevalid_opa_opb_illegal
// Expected cols show that cycle; issue and illegal come from the line before
0_00000000_1_01_1000000000000001_0_0_0000000000000000_0000000000000000_0 // wb x1
0_00000000_1_02_2000000000000002_0_0_0000000000000000_0000000000000000_0 // wb x2
0_00000000_1_03_3000000000000003_0_0_0000000000000000_0000000000000000_0 // wb x3
0_00000000_1_00_ffffffffffffffff_0_0_0000000000000000_0000000000000000_0 // wb x0 dropped
1_ffb08513_0_00_0000000000000000_0_0_0000000000000000_0000000000000000_0 // addi x10,x1,-5
1_003105b3_0_00_0000000000000000_0_1_1000000000000001_fffffffffffffffb_0 // add x11,x2,x3
1_00158633_1_0b_b00000000000000b_1_1_2000000000000002_3000000000000003_0 // add x12,x11,x1
1_00158633_0_00_0000000000000000_0_0_0000000000000000_0000000000000000_0 // Held, accepted
0_00000000_1_0c_c00000000000000c_0_1_b00000000000000b_1000000000000001_0 // Gap cycle
1_00760693_0_00_0000000000000000_0_0_0000000000000000_0000000000000000_0 // addi x13,x12,7
1_0080b703_0_00_0000000000000000_0_1_c00000000000000c_0000000000000007_0 // ld x14,8(x1)
1_00e107b3_0_00_0000000000000000_1_1_1000000000000001_0000000000000008_0 // add x15,x2,x14
1_00e107b3_1_0e_e00000000000000e_1_0_0000000000000000_0000000000000000_0 // Held
1_00e107b3_0_00_0000000000000000_0_0_0000000000000000_0000000000000000_0 // Held, accepted
1_00013803_0_00_0000000000000000_0_1_2000000000000002_e00000000000000e_0 // ld x16,0(x2)
1_01018893_0_00_0000000000000000_0_1_2000000000000002_0000000000000000_0 // addi x17,x3,16
1_00028913_1_05_5000000000000005_0_1_3000000000000003_0000000000000010_0 // addi x18,x5,0
1_000009b3_1_00_ffffffffffffffff_0_1_5000000000000005_0000000000000000_0 // add x19,x0,x0
1_0100ba03_0_00_0000000000000000_0_1_0000000000000000_0000000000000000_0 // ld x20,16(x1)
1_000a007f_1_14_2020202020202020_0_1_1000000000000001_0000000000000010_0 // Illegal opcode
1_014a0ab3_0_00_0000000000000000_0_0_0000000000000000_0000000000000000_1 // add x21,x20,x20
0_00000000_0_00_0000000000000000_0_1_2020202020202020_2020202020202020_0 // Drain
0_00000000_0_00_0000000000000000_0_0_0000000000000000_0000000000000000_0 // Idle

/* verif/tb_rv_issue.sv */
`timescale 1ns/1ps
`include "rv_issue_cfg.svh"

module tb_rv_issue
    import rv_issue_pkg::*;
();

    localparam int HALF_PERIOD    = 20;     // 40 ns clock
    localparam int RESET_CYCLES   = 8;
    localparam int TRACE_LINES    = 23;     // Lines in the trace file
    localparam int TIMEOUT_MARGIN = 20;

    // One trace line, fields nibble-aligned as written in the file
    typedef struct packed {
        logic [3:0]  instr_valid;
        logic [31:0] instr;
        logic [3:0]  wb_valid;
        logic [7:0]  wb_addr;
        logic [63:0] wb_data;
        logic [3:0]  stall;
        logic [3:0]  issue_valid;
        logic [63:0] op_a;
        logic [63:0] op_b;
        logic [3:0]  illegal;
    } trace_line_t;

    logic [$bits(trace_line_t)-1:0] trace_raw [0:TRACE_LINES-1];

    logic    clk;
    logic    rst_n;
    logic    instr_valid;
    instr_u  instr;
    wb_t     wb;
    logic    stall;
    logic    issue_valid;
    issue_t  issue;
    logic    illegal;
    int      cycle_count = 0;

    rv_issue_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb          (wb),
        .stall       (stall),
        .issue_valid (issue_valid),
        .issue       (issue),
        .illegal     (illegal)
    );

    always #HALF_PERIOD clk = ~clk;

    // ##############################
    // Run length guard
    // ##############################
    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count = cycle_count + 1;
            if (cycle_count > TRACE_LINES + TIMEOUT_MARGIN) begin
                $display("Timeout: trace not finished after %0d cycles", cycle_count);
                $display("Testbench failed");
                $fatal(1, "Run exceeded its cycle limit");
            end
        end
    end

    // ##############################
    // Drive and compare
    // ##############################
    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic drive_line(input trace_line_t t);
        instr_valid = t.instr_valid[0];
        instr       = instr_u'(t.instr);
        wb.valid    = t.wb_valid[0];
        wb.addr     = t.wb_addr[`RV_REG_AW-1:0];
        wb.data     = t.wb_data;
    endtask

    task automatic check_stall(input int line, input logic exp, input logic act);
        if (act !== exp) begin
            report_error($sformatf("error: trace line %0d stall: expected %0b, actual %0b",
                line, exp, act));
        end
    endtask

    // Operands are only meaningful while issue_valid is expected high
    task automatic check_issue(input int line, input logic exp_valid, input issue_t exp,
                               input logic act_valid, input issue_t act);
        if (act_valid !== exp_valid) begin
            report_error($sformatf("error: trace line %0d issue_valid: expected %0b, actual %0b",
                line, exp_valid, act_valid));
        end else if (exp_valid && (act.op_a !== exp.op_a)) begin
            report_error($sformatf("error: trace line %0d op_a: expected %h, actual %h",
                line, exp.op_a, act.op_a));
        end else if (exp_valid && (act.op_b !== exp.op_b)) begin
            report_error($sformatf("error: trace line %0d op_b: expected %h, actual %h",
                line, exp.op_b, act.op_b));
        end
    endtask

    task automatic check_illegal(input int line, input logic exp, input logic act);
        if (act !== exp) begin
            report_error($sformatf("error: trace line %0d illegal: expected %0b, actual %0b",
                line, exp, act));
        end
    endtask

    initial begin
        trace_line_t line_now;
        issue_t      exp_issue;

        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        wb          = '0;
        $readmemh("verif/rv_issue_trace.txt", trace_raw);

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < TRACE_LINES; i++) begin
            @(negedge clk);                             // Inputs change away from posedge
            line_now = trace_line_t'(trace_raw[i]);
            if ($isunknown(line_now) || (line_now.instr_valid > 4'd1)) begin
                report_error($sformatf("Trace line %0d is malformed or missing", i));
            end
            drive_line(line_now);
            #(HALF_PERIOD / 2);                         // Settle before the next posedge

            exp_issue      = '0;
            exp_issue.op_a = line_now.op_a;
            exp_issue.op_b = line_now.op_b;
            check_stall(i, line_now.stall[0], stall);
            check_issue(i, line_now.issue_valid[0], exp_issue, issue_valid, issue);
            check_illegal(i, line_now.illegal[0], illegal);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule
